/* dv/bkt_checker.sv */
/*
 * APB checker of the backtrack-level search testbench
 *   - compares read data, pslverr and wait states with the expectation
 *     that the testbench sets for the transfer in flight
 *   - flags pready or pslverr outside an access phase
 *   - counts transfers and errors
 */
`timescale 1ns/1ps
`default_nettype none

module bkt_checker (
    input  wire                         clk,
    input  wire                         rst,

    // Observed APB bus
    input  wire                         psel_i,
    input  wire                         penable_i,
    input  wire                         pwrite_i,
    input  wire  bkt_pkg::apb_addr_t    paddr_i,
    input  wire  bkt_pkg::apb_data_t    prdata_i,
    input  wire                         pready_i,
    input  wire                         pslverr_i,

    // Expectation from the model
    input  wire                         exp_chk_i,
    input  wire  bkt_pkg::apb_data_t    exp_rdata_i,
    input  wire                         exp_err_i,
    input  wire  [1:0]                  exp_waits_i,

    output logic [31:0]                 err_cnt_o,
    output logic [31:0]                 xfer_cnt_o
);

    import bkt_pkg::*;

    logic        access;
    logic [1:0]  wait_q;   // Access cycles with pready low
    int unsigned fails;

    assign access = psel_i & penable_i;

    always @(posedge clk)
    begin
        fails = 0;
        if (rst)
        begin
            wait_q     <= '0;
            err_cnt_o  <= '0;
            xfer_cnt_o <= '0;
        end
        else if (access && !pready_i)
            wait_q <= wait_q + 1'b1;
        else if (access)
        begin
            if (pslverr_i !== exp_err_i)
            begin
                $display("CHECK FAILED pslverr at paddr 0x%02h: expected 0x%0h, got 0x%0h",
                         paddr_i, exp_err_i, pslverr_i);
                fails++;
            end
            if (wait_q != exp_waits_i)
            begin
                $display("CHECK FAILED pready wait states at paddr 0x%02h: expected 0x%0h, got 0x%0h",
                         paddr_i, exp_waits_i, wait_q);
                fails++;
            end
            if (exp_chk_i && !pwrite_i && prdata_i !== exp_rdata_i)
            begin
                $display("CHECK FAILED prdata at paddr 0x%02h: expected 0x%08h, got 0x%08h",
                         paddr_i, exp_rdata_i, prdata_i);
                fails++;
            end
            wait_q     <= '0;
            xfer_cnt_o <= xfer_cnt_o + 1;
            err_cnt_o  <= err_cnt_o + fails;
        end
        else if (pready_i || pslverr_i)
        begin
            $display("pready or pslverr is high outside an APB access phase at %0t", $time);
            err_cnt_o <= err_cnt_o + 1;
        end
    end

endmodule

`default_nettype wire

/* dv/bkt_tb.sv */
/*
 * Testbench of the backtrack-level search subsystem
 *   - clock, reset, APB tasks driving on the falling edge
 *   - seeded random level-state contents and starting levels
 *   - reference model of the level memory and of the finder's walk
 *   - watchdog and closing report
 */
`timescale 1ns/1ps
`default_nettype none

module bkt_tb;

    import bkt_pkg::*;

    localparam int DEPTH_LOG2 = 9;
    localparam int CLK_PERIOD = 4;
    localparam int N_LVL      = 64;   // Levels exercised by the test
    localparam int N_SEARCH   = 40;
    localparam int SEARCH_CYC = 2 * (N_LVL + 1) + 2;   // Longest walk
    localparam int XFER_CYC   = 12 * N_LVL + 64;       // APB traffic around one search
    localparam int TIMEOUT_NS =
        (10 * N_LVL + N_SEARCH * (SEARCH_CYC + XFER_CYC)) * CLK_PERIOD * 2;

    logic       clk;
    logic       rst;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    apb_data_t  pwdata;
    apb_data_t  prdata;
    logic       pready;
    logic       pslverr;

    // Expectation for the transfer in flight
    logic       exp_chk;
    apb_data_t  exp_rdata;
    logic       exp_err;
    logic [1:0] exp_waits;

    logic [31:0] err_cnt;
    logic [31:0] xfer_cnt;

    lvl_state_t model_mem [0:N_LVL-1];

    bkt_subsys_top #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    bkt_checker i_chk (
        .clk         (clk),
        .rst         (rst),
        .psel_i      (psel),
        .penable_i   (penable),
        .pwrite_i    (pwrite),
        .paddr_i     (paddr),
        .prdata_i    (prdata),
        .pready_i    (pready),
        .pslverr_i   (pslverr),
        .exp_chk_i   (exp_chk),
        .exp_rdata_i (exp_rdata),
        .exp_err_i   (exp_err),
        .exp_waits_i (exp_waits),
        .err_cnt_o   (err_cnt),
        .xfer_cnt_o  (xfer_cnt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ##########################################################################
    // APB transfers, back to back, setup and access on falling edges
    task automatic apb_xfer(
        input  logic      wr,
        input  apb_addr_t addr,
        input  apb_data_t wdata,
        input  logic      chk,
        input  apb_data_t exp_data,
        input  logic      err,
        output apb_data_t rdata
    );
        @(negedge clk);
        psel      = 1'b1;
        penable   = 1'b0;
        pwrite    = wr;
        paddr     = addr;
        pwdata    = wdata;
        exp_chk   = chk;
        exp_rdata = exp_data;
        exp_err   = err;
        exp_waits = (!wr && addr == REG_LS_DATA && !err) ? 2'd1 : 2'd0;  // Memory latency
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready)
            @(posedge clk);
        rdata = prdata;
    endtask

    task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
        apb_data_t unused;
        apb_xfer(1'b1, addr, data, 1'b0, '0, 1'b0, unused);
    endtask

    task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
        apb_xfer(1'b0, addr, '0, 1'b0, '0, 1'b0, data);
    endtask

    task automatic read_expect(input apb_addr_t addr, input apb_data_t exp);
        apb_data_t unused;
        apb_xfer(1'b0, addr, '0, 1'b1, exp, 1'b0, unused);
    endtask

    // ##########################################################################
    // Level memory model
    task automatic write_entry(input int lvl, input lvl_state_t val);
        write_reg(REG_LS_ADDR, apb_data_t'(lvl));
        write_reg(REG_LS_DATA, {21'd0, val});
        model_mem[lvl] = val;
    endtask

    task automatic readback_all();
        int i;
        for (i = 0; i < N_LVL; i++)
        begin
            write_reg(REG_LS_ADDR, apb_data_t'(i));
            read_expect(REG_LS_DATA, {21'd0, model_mem[i]});
        end
    endtask

    function automatic lvl_state_t random_entry();
        bin_t bin;
        logic flag;
        bin  = bin_t'($urandom_range(1023, 0));
        flag = ($urandom_range(3, 0) != 0);  // Mostly flipped already
        return {bin, flag};
    endfunction

    // Walk down while flipped, then mark or give up at level 0
    task automatic predict_search(input int start, output int stop, output logic unsat);
        stop = start;
        while (model_mem[stop][0] && stop != 0)
            stop--;
        unsat = model_mem[stop][0];
        if (!unsat)
            model_mem[stop][0] = 1'b1;
    endtask

    // Refused while the finder owns the memory
    task automatic busy_access();
        apb_data_t unused;
        int        kind;
        kind = $urandom_range(2, 0);
        case (kind)
            0:       apb_xfer(1'b1, REG_LS_DATA, $urandom, 1'b0, '0, 1'b1, unused);
            1:       apb_xfer(1'b0, REG_LS_DATA, '0, 1'b0, '0, 1'b1, unused);
            default: apb_xfer(1'b1, REG_CTRL, 32'h1, 1'b0, '0, 1'b1, unused);
        endcase
    endtask

    task automatic run_search(input int n);
        int        start;
        int        stop;
        int        i;
        logic      unsat;
        apb_data_t status;
        start = $urandom_range(N_LVL - 1, 0);
        for (i = 0; i < 8; i++)
            write_entry($urandom_range(N_LVL - 1, 0), random_entry());
        if (n % 5 == 4)
        begin
            // Every level down to 0 already flipped
            for (i = 0; i <= start; i++)
                write_entry(i, {bin_t'($urandom_range(1023, 0)), 1'b1});
        end
        predict_search(start, stop, unsat);
        write_reg(REG_LVL_IN, apb_data_t'(start));
        write_reg(REG_CTRL, 32'h1);
        busy_access();   // Search lasts at least 4 cycles
        busy_access();
        status = 32'h1;
        while (status[0])
            read_reg(REG_STATUS, status);
        read_expect(REG_STATUS, {29'd0, unsat, 2'b10});
        read_expect(REG_RESULT, {6'd0, model_mem[stop][BIN_W:1], lvl_t'(stop)});
        readback_all();
    endtask

    // ##########################################################################
    // Main sequence
    initial
    begin
        int          n;
        int unsigned seed_val;
        seed_val  = $urandom(8998);
        clk       = 1'b0;
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        exp_chk   = 1'b0;
        exp_rdata = '0;
        exp_err   = 1'b0;
        exp_waits = 2'd0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (n = 0; n < N_LVL; n++)
            write_entry(n, random_entry());
        readback_all();
        for (n = 0; n < N_SEARCH; n++)
            run_search(n);

        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        repeat (2) @(posedge clk);
        $display("Done: %0d APB transfers checked, %0d errors", xfer_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: the test did not finish within %0d ns, %0d transfers, %0d errors",
                 TIMEOUT_NS, xfer_cnt, err_cnt);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
verilog/bkt_pkg.sv
verilog/bkt_apb_regs.sv
verilog/lvl_state_ram.sv
verilog/find_global_bkt_lvl.sv
verilog/bkt_subsys_top.sv
dv/bkt_checker.sv
dv/bkt_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module bkt_tb -f filelist.f -o bkt_sim &&
./obj_dir/bkt_sim | tee sim.log &&
grep -qx "Regression passed" sim.log &&
echo "Simulation OK" ||
{ echo "Simulation FAILED"; exit 1; }

/* verilog/bkt_apb_regs.sv */
/*
 * APB3 slave of the backtrack-level search subsystem
 *   - control, status, result and level-state access registers
 *   - start pulse towards the finder, result capture on done
 *   - one wait state on level-state reads, refusal while busy
 */
`timescale 1ns/1ps
`default_nettype none

module bkt_apb_regs #(
    parameter int DEPTH_LOG2 = 9
) (
    input  wire                         clk,
    input  wire                         rst,

    // APB slave
    input  wire                         psel_i,
    input  wire                         penable_i,
    input  wire                         pwrite_i,
    input  wire  bkt_pkg::apb_addr_t    paddr_i,
    input  wire  bkt_pkg::apb_data_t    pwdata_i,
    output logic [31:0]                 prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,

    // Finder
    output logic                        start_find_o,
    output bkt_pkg::lvl_t               bkt_lvl_o,
    input  wire                         done_find_i,
    input  wire  bkt_pkg::lvl_t         res_lvl_i,
    input  wire  bkt_pkg::bin_t         res_bin_i,
    input  wire                         unsat_i,

    // Level-state memory, host side
    output logic                        host_req_o,
    output logic                        host_we_o,
    output logic [DEPTH_LOG2-1:0]       host_addr_o,
    output bkt_pkg::lvl_state_t         host_wdata_o,
    input  wire  bkt_pkg::lvl_state_t   host_rdata_i
);

    import bkt_pkg::*;

    logic                  access;
    logic                  ls_hit;
    logic                  ctrl_start_wr;
    logic                  refuse;
    logic                  wr_en;
    logic                  ls_rd_first;
    apb_data_t             rd_data;

    logic                  busy_q;
    logic                  done_q;
    logic                  unsat_q;
    logic                  rd_wait_q;  // Second cycle of a memory read
    lvl_t                  lvl_in_q;
    logic [DEPTH_LOG2-1:0] ls_addr_q;
    lvl_t                  res_lvl_q;
    bin_t                  res_bin_q;

    // ##########################################################################
    // Decode
    assign access        = psel_i & penable_i;
    assign ls_hit        = (paddr_i == REG_LS_DATA);
    assign ctrl_start_wr = pwrite_i && (paddr_i == REG_CTRL) && pwdata_i[0];

    // Finder owns the memory while busy
    assign refuse      = access && busy_q && (ls_hit || ctrl_start_wr);
    assign wr_en       = access && pwrite_i && !refuse;
    assign ls_rd_first = access && ls_hit && !pwrite_i && !busy_q && !rd_wait_q;

    assign pready_o  = access && !ls_rd_first;
    assign pslverr_o = refuse;

    assign start_find_o = wr_en && (paddr_i == REG_CTRL) && pwdata_i[0];
    assign bkt_lvl_o    = lvl_in_q;

    assign host_req_o   = (wr_en && ls_hit) || ls_rd_first;
    assign host_we_o    = pwrite_i;
    assign host_addr_o  = ls_addr_q;
    assign host_wdata_o = pwdata_i[BIN_W:0];

    // ##########################################################################
    // Control and status
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            unsat_q   <= 1'b0;
            rd_wait_q <= 1'b0;
        end
        else
        begin
            rd_wait_q <= ls_rd_first;
            if (start_find_o)
            begin
                busy_q  <= 1'b1;
                done_q  <= 1'b0;
                unsat_q <= 1'b0;
            end
            else if (done_find_i)
            begin
                busy_q  <= 1'b0;
                done_q  <= 1'b1;  // Sticky until next start
                unsat_q <= unsat_i;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lvl_in_q  <= '0;
            ls_addr_q <= '0;
            res_lvl_q <= '0;
            res_bin_q <= '0;
        end
        else
        begin
            if (wr_en && paddr_i == REG_LVL_IN)
                lvl_in_q <= pwdata_i[LVL_W-1:0];
            if (wr_en && paddr_i == REG_LS_ADDR)
                ls_addr_q <= pwdata_i[DEPTH_LOG2-1:0];
            if (done_find_i)
            begin
                res_lvl_q <= res_lvl_i;
                res_bin_q <= res_bin_i;
            end
        end
    end

    // ##########################################################################
    // Read mux, unknown offsets read as zero
    always_comb
    begin
        rd_data = '0;
        case (paddr_i)
            REG_LVL_IN:  rd_data[LVL_W-1:0] = lvl_in_q;
            REG_STATUS:  rd_data[2:0] = {unsat_q, done_q, busy_q};
            REG_RESULT:
            begin
                rd_data[LVL_W-1:0]      = res_lvl_q;
                rd_data[LVL_W +: BIN_W] = res_bin_q;
            end
            REG_LS_ADDR: rd_data[DEPTH_LOG2-1:0] = ls_addr_q;
            REG_LS_DATA: rd_data[BIN_W:0] = host_rdata_i;  // Valid in wait cycle
            default:     rd_data = '0;
        endcase
    end

    assign prdata_o = (access && !pwrite_i && !refuse) ? rd_data : '0;

endmodule

`default_nettype wire

/* verilog/bkt_pkg.sv */
/*
 * Shared definitions for the backtrack-level search subsystem
 *   - bin id and decision level widths with their vector types
 *   - level-state entry layout, bin id above the has_bkt flag
 *   - APB address and data types, register offsets
 *   - finder FSM state encoding
 */
`default_nettype none

package bkt_pkg;

    localparam int BIN_W = 10;
    localparam int LVL_W = 16;

    typedef logic [LVL_W-1:0] lvl_t;
    typedef logic [BIN_W-1:0] bin_t;
    typedef logic [BIN_W:0]   lvl_state_t;  // {bin, has_bkt}

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // ##########################################################################
    // Register map
    localparam apb_addr_t REG_CTRL    = 8'h00;  // Bit 0 starts a search
    localparam apb_addr_t REG_LVL_IN  = 8'h04;
    localparam apb_addr_t REG_STATUS  = 8'h08;  // {unsat, done, busy}
    localparam apb_addr_t REG_RESULT  = 8'h0C;  // {bin, level}
    localparam apb_addr_t REG_LS_ADDR = 8'h10;
    localparam apb_addr_t REG_LS_DATA = 8'h14;

    typedef enum logic [2:0] {
        IDLE,
        READ,
        CHECK,
        MARK,
        DONE
    } find_state_e;

endpackage

`default_nettype wire

/* verilog/bkt_subsys_top.sv */
/*
 * Backtrack-level search subsystem top
 *   - APB front end, level-state memory, finder
 */
`timescale 1ns/1ps
`default_nettype none

module bkt_subsys_top #(
    parameter int DEPTH_LOG2 = 9
) (
    input  wire                         clk,
    input  wire                         rst,

    input  wire                         psel_i,
    input  wire                         penable_i,
    input  wire                         pwrite_i,
    input  wire  bkt_pkg::apb_addr_t    paddr_i,
    input  wire  bkt_pkg::apb_data_t    pwdata_i,
    output logic [31:0]                 prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o
);

    import bkt_pkg::*;

    // Front end to finder
    logic                  start_find;
    lvl_t                  start_lvl;
    logic                  done_find;
    lvl_t                  res_lvl;
    bin_t                  res_bin;
    logic                  unsat;

    // Memory ports
    logic                  host_req;
    logic                  host_we;
    logic [DEPTH_LOG2-1:0] host_addr;
    lvl_state_t            host_wdata;
    lvl_state_t            host_rdata;
    logic                  apply_find;
    logic                  ram_we;
    logic [DEPTH_LOG2-1:0] ram_addr;
    lvl_state_t            ram_wdata;
    lvl_state_t            ram_rdata;

    bkt_apb_regs #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) u_regs (
        .clk          (clk),
        .rst          (rst),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .start_find_o (start_find),
        .bkt_lvl_o    (start_lvl),
        .done_find_i  (done_find),
        .res_lvl_i    (res_lvl),
        .res_bin_i    (res_bin),
        .unsat_i      (unsat),
        .host_req_o   (host_req),
        .host_we_o    (host_we),
        .host_addr_o  (host_addr),
        .host_wdata_o (host_wdata),
        .host_rdata_i (host_rdata)
    );

    lvl_state_ram #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) u_ram (
        .clk          (clk),
        .host_req_i   (host_req),
        .host_we_i    (host_we),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .host_rdata_o (host_rdata),
        .apply_find_i (apply_find),
        .ram_we_i     (ram_we),
        .ram_addr_i   (ram_addr),
        .ram_wdata_i  (ram_wdata),
        .ram_rdata_o  (ram_rdata)
    );

    find_global_bkt_lvl #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) u_find (
        .clk          (clk),
        .rst          (rst),
        .start_find   (start_find),
        .bkt_lvl_i    (start_lvl),
        .done_find    (done_find),
        .bkt_lvl_o    (res_lvl),
        .bkt_bin_o    (res_bin),
        .unsat_o      (unsat),
        .apply_find_o (apply_find),
        .ram_we_o     (ram_we),
        .ram_addr_o   (ram_addr),
        .ram_wdata_o  (ram_wdata),
        .ram_rdata_i  (ram_rdata)
    );

endmodule

`default_nettype wire

/* verilog/find_global_bkt_lvl.sv */
/*
 * Global backtrack-level finder
 *   - walks the level-state memory down from the starting level
 *   - stops at the first level with has_bkt clear, or at level 0
 *   - marks that level as flipped, or reports unsat when exhausted
 */
`timescale 1ns/1ps
`default_nettype none

module find_global_bkt_lvl #(
    parameter int DEPTH_LOG2 = 9
) (
    input  wire                         clk,
    input  wire                         rst,

    // Control
    input  wire                         start_find,
    input  wire  bkt_pkg::lvl_t         bkt_lvl_i,
    output logic                        done_find,
    output bkt_pkg::lvl_t               bkt_lvl_o,
    output bkt_pkg::bin_t               bkt_bin_o,
    output logic                        unsat_o,

    // Level-state memory
    output logic                        apply_find_o,
    output logic                        ram_we_o,
    output logic [DEPTH_LOG2-1:0]       ram_addr_o,
    output bkt_pkg::lvl_state_t         ram_wdata_o,
    input  wire  bkt_pkg::lvl_state_t   ram_rdata_i
);

    import bkt_pkg::*;

    find_state_e state_q;
    find_state_e state_d;
    lvl_t        lvl_cnt_q;
    bin_t        bin_q;
    logic        unsat_q;
    logic        has_bkt;
    logic        walk_on;

    assign has_bkt = ram_rdata_i[0];
    assign walk_on = has_bkt && (lvl_cnt_q != '0);  // Keep descending

    // ##########################################################################
    // State machine
    always_ff @(posedge clk)
    begin
        if (rst)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
                if (start_find)
                    state_d = READ;
            READ:
                state_d = CHECK;  // Wait for read data
            CHECK:
                if (walk_on)
                    state_d = READ;
                else
                    state_d = MARK;
            MARK:
                state_d = DONE;
            DONE:
                state_d = IDLE;
            default:
                state_d = IDLE;
        endcase
    end

    // ##########################################################################
    // Level counter and result
    always_ff @(posedge clk)
    begin
        if (state_q == IDLE && start_find)
            lvl_cnt_q <= bkt_lvl_i;
        else if (state_q == CHECK)
        begin
            bin_q   <= ram_rdata_i[BIN_W:1];
            unsat_q <= has_bkt;  // Only kept when the walk stops
            if (walk_on)
                lvl_cnt_q <= lvl_cnt_q - 1'b1;
        end
    end

    assign bkt_lvl_o = lvl_cnt_q;
    assign bkt_bin_o = bin_q;
    assign unsat_o   = unsat_q;
    assign done_find = (state_q == DONE);

    // Memory port, held from start to done
    assign apply_find_o = (state_q != IDLE);
    assign ram_addr_o   = lvl_cnt_q[DEPTH_LOG2-1:0];
    assign ram_we_o     = (state_q == MARK) && !unsat_q;
    assign ram_wdata_o  = {bin_q, 1'b1};  // Same bin, flipped once

    // ##########################################################################
    // Assertions

    // Marked entry comes back through the port in the cycle after DONE
    a_we_marks_last_level: assert property (
        @(posedge clk) disable iff (rst)
        $past(ram_we_o, 2) |-> ram_rdata_i == $past(ram_wdata_o, 2)
    ) else $error("marked level-state entry did not read back as written");

    a_done_pulse: assert property (
        @(posedge clk) disable iff (rst)
        done_find |=> !done_find
    ) else $error("done_find longer than one cycle");

    // Front end refuses a start while a search runs
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        start_find |-> state_q == IDLE
    ) else $error("start_find during a search");

endmodule

`default_nettype wire

/* verilog/lvl_state_ram.sv */
/*
 * Level-state memory
 *   - one synchronous single-port array of {bin, has_bkt} entries
 *   - port mux between host and finder, read data to both
 */
`timescale 1ns/1ps
`default_nettype none

module lvl_state_ram #(
    parameter int DEPTH_LOG2 = 9
) (
    input  wire                         clk,

    // Host side
    input  wire                         host_req_i,
    input  wire                         host_we_i,
    input  wire  [DEPTH_LOG2-1:0]       host_addr_i,
    input  wire  bkt_pkg::lvl_state_t   host_wdata_i,
    output bkt_pkg::lvl_state_t         host_rdata_o,

    // Finder side
    input  wire                         apply_find_i,
    input  wire                         ram_we_i,
    input  wire  [DEPTH_LOG2-1:0]       ram_addr_i,
    input  wire  bkt_pkg::lvl_state_t   ram_wdata_i,
    output bkt_pkg::lvl_state_t         ram_rdata_o
);

    import bkt_pkg::*;

    localparam int DEPTH = 1 << DEPTH_LOG2;

    lvl_state_t            mem [0:DEPTH-1];
    lvl_state_t            rdata_q;
    logic [DEPTH_LOG2-1:0] addr;
    logic                  we;
    lvl_state_t            wdata;

    // Finder has the port for the whole search
    assign addr  = apply_find_i ? ram_addr_i  : host_addr_i;
    assign we    = apply_find_i ? ram_we_i    : (host_req_i & host_we_i);
    assign wdata = apply_find_i ? ram_wdata_i : host_wdata_i;

    always_ff @(posedge clk)
    begin
        if (we)
            mem[addr] <= wdata;
        rdata_q <= mem[addr];  // Read-first, 1 cycle latency
    end

    assign host_rdata_o = rdata_q;
    assign ram_rdata_o  = rdata_q;

    // Front end must not touch the memory during a search
    a_no_host_during_find: assert property (
        @(posedge clk) $rose(host_req_i) |-> !apply_find_i
    ) else $error("host request raised while finder owns the memory");

endmodule

`default_nettype wire
